/* build.f */
verilog/rv_id_pkg.sv
verilog/rv_imm_gen.sv
verilog/rv_ctrl_decoder.sv
verilog/rv_gpr_file.sv
verilog/rv_id_stage.sv
sim/rv_id_stage_chk.sv
sim/rv_id_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv_id_stage_tb -o Vrv_id_stage_tb -f build.f

status=0
./obj_dir/Vrv_id_stage_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "All tests passed" sim.log; then
    echo "simulation did not finish cleanly"
    exit 1
fi
echo "simulation passed"

/* sim/rv_id_stage_chk.sv */
// --------------------------------------------------
// decode stage assertions
// reset state, stall stability of the id/ex
// register, illegal results left inactive
// --------------------------------------------------
`timescale 1ns/1ps

module rv_id_stage_chk import rv_id_pkg::*; (
    input logic   clk_i,
    input logic   arst_n_i,
    input logic   id_valid_i,
    input logic   ex_ready_i,
    input id_ex_t id_ex_i
);

    // first edge out of reset, nothing in the stage
    a_reset_empty: assert property (
        @(posedge clk_i) $rose(arst_n_i) |-> !id_valid_i
    ) else $error("id_valid_o high right after reset");

    // stalled result holds still
    a_stall_hold: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (id_valid_i && !ex_ready_i) |=> (id_valid_i && $stable(id_ex_i))
    ) else $error("id/ex result changed under back-pressure");

    // illegal results neither write a register nor touch memory
    a_illegal_idle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (id_valid_i && id_ex_i.illegal) |-> (!id_ex_i.gpr_we && (id_ex_i.mem_op == MEM_NOP))
    ) else $error("illegal result with active write or memory control");

endmodule

/* sim/rv_id_stage_tb.sv */
// --------------------------------------------------
// testbench for the rv32i decode stage
// random instruction stream under random stalls,
// checked against a behavioral decode model
// --------------------------------------------------
`timescale 1ns/1ps

module rv_id_stage_tb import rv_id_pkg::*; ();

    localparam int unsigned clk_period_p = 4;
    localparam int unsigned rst_cycles_p = 16;
    localparam int unsigned n_insn_p     = 2000;
    localparam int unsigned nregs_p      = 32;
    localparam int unsigned timeout_ns_p = n_insn_p * 8 * clk_period_p
                                         + rst_cycles_p * clk_period_p;
    localparam logic [31:0] seed_p       = 32'h67e6_677b;

    logic              clk;
    logic              arst_n;
    logic              if_valid;
    logic              if_ready;
    insn_u             if_insn;
    logic              id_valid;
    logic              ex_ready;
    id_ex_t            id_ex;
    logic              wb_we;
    reg_addr_t         wb_addr;
    logic [xlen_p-1:0] wb_data;

    // register mirror and in-flight expectations
    logic [xlen_p-1:0] model_regs [nregs_p];
    id_ex_t            exp_q [$];
    logic [31:0]       insn_q [$];
    int unsigned       n_accepted = 0;
    int unsigned       n_consumed = 0;

    rv_id_stage #(
        .DATA_W (xlen_p),
        .NREGS  (nregs_p)
    ) UUT (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .if_valid_i (if_valid),
        .if_ready_o (if_ready),
        .if_insn_i  (if_insn),
        .id_valid_o (id_valid),
        .ex_ready_i (ex_ready),
        .id_ex_o    (id_ex),
        .wb_we_i    (wb_we),
        .wb_addr_i  (wb_addr),
        .wb_data_i  (wb_data)
    );

    // handshake and illegal-result assertions
    bind rv_id_stage rv_id_stage_chk u_chk (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .id_valid_i (id_valid_o),
        .ex_ready_i (ex_ready_i),
        .id_ex_i    (id_ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_p / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // error reporting and compare tasks
    // --------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input logic [31:0] insn);
        if (got !== exp) begin
            stop_on_error($sformatf("insn %h decoded to %h, expected %h", insn, got, exp));
        end
    endtask

    task automatic check_count(input int unsigned got, input int unsigned exp);
        if (got != exp) begin
            stop_on_error($sformatf("%0d results consumed, %0d accepted", got, exp));
        end
    endtask

    // --------------------------------------------------
    // reference decode, straight from the rv32i tables
    // --------------------------------------------------
    function automatic id_ex_t model_decode(input logic [31:0] w);
        id_ex_t      e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic        is_imm;
        logic        legal;
        logic        alt;
        f3     = w[14:12];
        f7     = w[31:25];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
        is_imm = (w[6:0] == 7'b0010011);
        // sub / sra only where the encoding allows it
        alt    = (f7 == 7'b0100000) && ((f3 == 3'd5) || (!is_imm && (f3 == 3'd0)));
        // controls idle, operands straight from the registers
        e             = '0;
        e.alu_in_0    = model_regs[w[19:15]];
        e.alu_in_1    = model_regs[w[24:20]];
        e.mem_wr_data = model_regs[w[24:20]];
        e.dst_addr    = w[11:7];
        case (w[6:0])
            7'b0000011: begin
                case (f3)
                    3'd0:    e.mem_op = MEM_LB;
                    3'd1:    e.mem_op = MEM_LH;
                    3'd2:    e.mem_op = MEM_LW;
                    3'd4:    e.mem_op = MEM_LBU;
                    3'd5:    e.mem_op = MEM_LHU;
                    default: e.illegal = 1'b1;
                endcase
                if (!e.illegal) begin
                    e.alu_op   = ALU_ADD;
                    e.alu_in_1 = imm_i;
                    e.wb_sel   = WB_MEM;
                    e.gpr_we   = 1'b1;
                end
            end
            7'b0100011: begin
                case (f3)
                    3'd0:    e.mem_op = MEM_SB;
                    3'd1:    e.mem_op = MEM_SH;
                    3'd2:    e.mem_op = MEM_SW;
                    default: e.illegal = 1'b1;
                endcase
                if (!e.illegal) begin
                    e.alu_op   = ALU_ADD;
                    e.alu_in_1 = imm_s;
                end
            end
            7'b0010011, 7'b0110011: begin
                // op-imm only checks funct7 on shifts
                if (is_imm) begin
                    legal = (f3 == 3'd1) ? (f7 == 7'd0) :
                            (f3 == 3'd5) ? ((f7 == 7'd0) || alt) : 1'b1;
                end else begin
                    legal = (f7 == 7'd0) || alt;
                end
                if (!legal) begin
                    e.illegal = 1'b1;
                end else begin
                    case (f3)
                        3'd0: e.alu_op = alt ? ALU_SUB : ALU_ADD;
                        3'd1: e.alu_op = ALU_SLL;
                        3'd2: begin
                            e.cmp_op     = CMP_LT;
                            e.ex_out_sel = EX_OUT_CMP;
                        end
                        3'd3: begin
                            e.cmp_op     = CMP_LTU;
                            e.ex_out_sel = EX_OUT_CMP;
                        end
                        3'd4: e.alu_op = ALU_XOR;
                        3'd5: e.alu_op = alt ? ALU_SRA : ALU_SRL;
                        3'd6: e.alu_op = ALU_OR;
                        3'd7: e.alu_op = ALU_AND;
                    endcase
                    e.gpr_we = 1'b1;
                    // shifts take the 5-bit amount only
                    if (is_imm) begin
                        e.alu_in_1 = ((f3 == 3'd1) || (f3 == 3'd5)) ? {27'd0, w[24:20]} : imm_i;
                    end
                end
            end
            default: e.illegal = 1'b1;
        endcase
        return e;
    endfunction

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] random_insn();
        logic [31:0] w;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        alt;
        int unsigned kind;
        w = $urandom();
        // raw random words, mostly undefined
        if ($urandom_range(99, 0) < 30) begin
            return w;
        end
        f3   = w[14:12];
        f7   = w[31:25];
        alt  = ($urandom_range(1, 0) == 1);
        kind = $urandom_range(3, 0);
        case (kind)
            0: begin
                opc = 7'b0000011;
                // skip the hole at funct3 3
                f3 = 3'($urandom_range(4, 0));
                if (f3 > 3'd2) begin
                    f3 = f3 + 3'd1;
                end
            end
            1: begin
                opc = 7'b0100011;
                f3  = 3'($urandom_range(2, 0));
            end
            2: begin
                opc = 7'b0010011;
                if ((f3 == 3'd1) || (f3 == 3'd5)) begin
                    f7 = (alt && (f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
                end
            end
            default: begin
                opc = 7'b0110011;
                f7  = (alt && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'b0100000 : 7'b0000000;
            end
        endcase
        return {f7, w[24:15], f3, w[11:7], opc};
    endfunction

    function automatic logic random_ready();
        return ($urandom_range(99, 0) < 60);
    endfunction

    // hold one instruction until the stage takes it
    task automatic offer_insn(input logic [31:0] insn);
        logic done;
        done = 1'b0;
        if_valid <= 1'b1;
        if_insn  <= insn;
        ex_ready <= random_ready();
        while (!done) begin
            @(posedge clk);
            if (if_ready) begin
                done = 1'b1;
            end else begin
                ex_ready <= random_ready();
            end
        end
    endtask

    // --------------------------------------------------
    // monitor, consume before accept on the same edge
    // --------------------------------------------------
    always @(posedge clk) begin
        if (arst_n) begin
            if (id_valid && ex_ready) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("a result came out with no instruction pending");
                end else begin
                    check_id_ex(id_ex, exp_q.pop_front(), insn_q.pop_front());
                    n_consumed++;
                end
            end
            if (if_valid && if_ready) begin
                exp_q.push_back(model_decode(if_insn));
                insn_q.push_back(if_insn);
                n_accepted++;
            end
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] data;
        void'($urandom(seed_p));
        arst_n   = 1'b0;
        if_valid = 1'b0;
        if_insn  = '0;
        ex_ready = 1'b0;
        wb_we    = 1'b0;
        wb_addr  = '0;
        wb_data  = '0;
        repeat (rst_cycles_p) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_flag("id_valid_o after reset", id_valid, 1'b0);
        check_flag("if_ready_o after reset", if_ready, 1'b1);

        // fill every register, x0 write must be dropped
        for (int i = 0; i < nregs_p; i++) begin
            data = $urandom();
            wb_we   <= 1'b1;
            wb_addr <= reg_addr_t'(i);
            wb_data <= data;
            model_regs[i] = (i == 0) ? '0 : data;
            @(posedge clk);
        end
        wb_we <= 1'b0;

        repeat (n_insn_p) begin
            // random bubbles on the fetch side
            while ($urandom_range(3, 0) == 0) begin
                if_valid <= 1'b0;
                ex_ready <= random_ready();
                @(posedge clk);
            end
            offer_insn(random_insn());
        end

        // drain the stage, the single result register empties in one edge
        if_valid <= 1'b0;
        ex_ready <= 1'b1;
        repeat (3) @(posedge clk);
        check_flag("id_valid_o after drain", id_valid, 1'b0);
        check_count(n_consumed, n_accepted);

        $display("All tests passed");
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_ns_p);
        $display("timeout: the run did not finish within %0d ns", timeout_ns_p);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verilog/rv_ctrl_decoder.sv */
// ------------------------------------------------
// rv32i control decoder
// loads, stores, op-imm and op groups into alu,
// compare, memory and writeback controls
// undefined encodings raise illegal and leave
// every other control inactive
// ------------------------------------------------
`timescale 1ns/1ps

module rv_ctrl_decoder import rv_id_pkg::*; (
    input  insn_u       insn_i,
    output alu_op_e     alu_op_o,
    output cmp_op_e     cmp_op_o,
    output mem_op_e     mem_op_o,
    output imm_fmt_e    imm_fmt_o,
    output logic        use_imm_o,
    output ex_out_sel_e ex_out_sel_o,
    output wb_sel_e     wb_sel_o,
    output logic        gpr_we_o,
    output logic        illegal_o
);

    // ------------------------------------------------
    // field extraction and funct7 qualifiers
    // ------------------------------------------------
    logic [2:0] funct3;
    logic       f7_base;
    logic       f7_alt;
    logic       is_shift;
    logic       alt_imm;
    logic       alt_reg;
    logic       bad_imm;
    logic       bad_reg;
    cmp_op_e    slt_cmp;

    assign funct3  = insn_i.r_fmt.funct3;
    assign f7_base = (insn_i.r_fmt.funct7 == f7_base_p);
    assign f7_alt  = (insn_i.r_fmt.funct7 == f7_alt_p);

    assign is_shift = (funct3 == f3_sll_p) || (funct3 == f3_sr_p);

    // op-imm, only the right shift has an alternate form (srai)
    assign alt_imm = f7_alt && (funct3 == f3_sr_p);
    // op, sub and sra
    assign alt_reg = f7_alt && ((funct3 == f3_add_p) || (funct3 == f3_sr_p));

    // op-imm, funct7 only constrained on shifts
    assign bad_imm = ((funct3 == f3_sll_p) && !f7_base) ||
                     ((funct3 == f3_sr_p) && !f7_base && !f7_alt);
    // op, funct7 must be base unless it is a legal alternate
    assign bad_reg = !f7_base && !alt_reg;

    // slt family goes through the comparator, not the alu
    assign slt_cmp = (funct3 == f3_slt_p)  ? CMP_LT  :
                     (funct3 == f3_sltu_p) ? CMP_LTU : CMP_NOP;

    // funct3 to alu operation, same map for op and op-imm
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            f3_add_p: op = alt ? ALU_SUB : ALU_ADD;
            f3_sll_p: op = ALU_SLL;
            f3_xor_p: op = ALU_XOR;
            f3_sr_p:  op = alt ? ALU_SRA : ALU_SRL;
            f3_or_p:  op = ALU_OR;
            f3_and_p: op = ALU_AND;
            // slt / sltu leave the alu idle
            default:  op = ALU_NOP;
        endcase
        return op;
    endfunction

    // ------------------------------------------------
    // main decode
    // ------------------------------------------------
    always_comb begin
        // inactive defaults, illegal paths only touch illegal_o
        alu_op_o     = ALU_NOP;
        cmp_op_o     = CMP_NOP;
        mem_op_o     = MEM_NOP;
        imm_fmt_o    = IMM_NONE;
        use_imm_o    = 1'b0;
        ex_out_sel_o = EX_OUT_ALU;
        wb_sel_o     = WB_EX;
        gpr_we_o     = 1'b0;
        illegal_o    = 1'b0;

        case (insn_i.r_fmt.opcode)
            OPC_LOAD: begin
                case (funct3)
                    f3_lb_p:  mem_op_o = MEM_LB;
                    f3_lh_p:  mem_op_o = MEM_LH;
                    f3_lw_p:  mem_op_o = MEM_LW;
                    f3_lbu_p: mem_op_o = MEM_LBU;
                    f3_lhu_p: mem_op_o = MEM_LHU;
                    default:  illegal_o = 1'b1;
                endcase
                // address = rs1 + imm_i, data comes back from mem
                if (!illegal_o) begin
                    alu_op_o  = ALU_ADD;
                    imm_fmt_o = IMM_I;
                    use_imm_o = 1'b1;
                    wb_sel_o  = WB_MEM;
                    gpr_we_o  = 1'b1;
                end
            end

            OPC_STORE: begin
                case (funct3)
                    f3_sb_p: mem_op_o = MEM_SB;
                    f3_sh_p: mem_op_o = MEM_SH;
                    f3_sw_p: mem_op_o = MEM_SW;
                    default: illegal_o = 1'b1;
                endcase
                // address = rs1 + imm_s, no register write
                if (!illegal_o) begin
                    alu_op_o  = ALU_ADD;
                    imm_fmt_o = IMM_S;
                    use_imm_o = 1'b1;
                end
            end

            OPC_OP_IMM: begin
                if (bad_imm) begin
                    illegal_o = 1'b1;
                end else begin
                    alu_op_o     = f3_to_alu(funct3, alt_imm);
                    cmp_op_o     = slt_cmp;
                    ex_out_sel_o = (slt_cmp != CMP_NOP) ? EX_OUT_CMP : EX_OUT_ALU;
                    imm_fmt_o    = is_shift ? IMM_ISHIFT : IMM_I;
                    use_imm_o    = 1'b1;
                    wb_sel_o     = WB_EX;
                    gpr_we_o     = 1'b1;
                end
            end

            OPC_OP: begin
                if (bad_reg) begin
                    illegal_o = 1'b1;
                end else begin
                    // both operands from the register file
                    alu_op_o     = f3_to_alu(funct3, alt_reg);
                    cmp_op_o     = slt_cmp;
                    ex_out_sel_o = (slt_cmp != CMP_NOP) ? EX_OUT_CMP : EX_OUT_ALU;
                    wb_sel_o     = WB_EX;
                    gpr_we_o     = 1'b1;
                end
            end

            // branches, jumps, lui, auipc and anything unknown
            default: begin
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

/* verilog/rv_gpr_file.sv */
// ------------------------------------------------
// general purpose register file
// two combinational read ports, one write port
// on the rising edge, x0 hardwired to zero
// ------------------------------------------------
`timescale 1ns/1ps

module rv_gpr_file import rv_id_pkg::*; #(
    parameter int unsigned DATA_W = xlen_p,
    parameter int unsigned NREGS  = 32
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // read side
    input  reg_addr_t         rd_addr_0_i,
    input  reg_addr_t         rd_addr_1_i,
    output logic [DATA_W-1:0] rd_data_0_o,
    output logic [DATA_W-1:0] rd_data_1_o,
    // write side
    input  logic              we_i,
    input  reg_addr_t         wr_addr_i,
    input  logic [DATA_W-1:0] wr_data_i
);

    // ------------------------------------------------
    // storage
    // ------------------------------------------------
    logic [DATA_W-1:0] regs [NREGS];

    // whole array cleared on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            // writes to x0 dropped
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // ------------------------------------------------
    // read ports
    // ------------------------------------------------
    // no write-through, a same-cycle write shows up next cycle
    assign rd_data_0_o = (rd_addr_0_i == '0) ? '0 : regs[rd_addr_0_i];
    assign rd_data_1_o = (rd_addr_1_i == '0) ? '0 : regs[rd_addr_1_i];

endmodule

/* verilog/rv_id_pkg.sv */
// ------------------------------------------------
// rv32i decode stage shared definitions
// opcodes, function codes, control encodings,
// the instruction word views and the id/ex result
// ------------------------------------------------

package rv_id_pkg;

    // ------------------------------------------------
    // widths
    // ------------------------------------------------
    localparam int unsigned xlen_p = 32;

    typedef logic [4:0] reg_addr_t;

    // ------------------------------------------------
    // major opcodes, only the kept subset
    // ------------------------------------------------
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // funct3 for loads
    localparam logic [2:0] f3_lb_p  = 3'b000;
    localparam logic [2:0] f3_lh_p  = 3'b001;
    localparam logic [2:0] f3_lw_p  = 3'b010;
    localparam logic [2:0] f3_lbu_p = 3'b100;
    localparam logic [2:0] f3_lhu_p = 3'b101;

    // funct3 for stores
    localparam logic [2:0] f3_sb_p = 3'b000;
    localparam logic [2:0] f3_sh_p = 3'b001;
    localparam logic [2:0] f3_sw_p = 3'b010;

    // funct3 for alu ops, shared by op and op-imm
    localparam logic [2:0] f3_add_p  = 3'b000;
    localparam logic [2:0] f3_sll_p  = 3'b001;
    localparam logic [2:0] f3_slt_p  = 3'b010;
    localparam logic [2:0] f3_sltu_p = 3'b011;
    localparam logic [2:0] f3_xor_p  = 3'b100;
    localparam logic [2:0] f3_sr_p   = 3'b101;
    localparam logic [2:0] f3_or_p   = 3'b110;
    localparam logic [2:0] f3_and_p  = 3'b111;

    // funct7, base and alternate (sub / sra)
    localparam logic [6:0] f7_base_p = 7'b0000000;
    localparam logic [6:0] f7_alt_p  = 7'b0100000;

    // ------------------------------------------------
    // control encodings
    // ------------------------------------------------
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        CMP_NOP, CMP_LT, CMP_LTU
    } cmp_op_e;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        IMM_NONE, IMM_I, IMM_ISHIFT, IMM_S
    } imm_fmt_e;

    // ex stage result source
    typedef enum logic {
        EX_OUT_ALU, EX_OUT_CMP
    } ex_out_sel_e;

    // writeback source
    typedef enum logic {
        WB_EX, WB_MEM
    } wb_sel_e;

    // ------------------------------------------------
    // instruction word, two views of the same bits
    // ------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // s format, imm split around rs1/rs2
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        s_fmt_t s_fmt;
    } insn_u;

    // ------------------------------------------------
    // id/ex pipeline register contents
    // ------------------------------------------------
    typedef struct packed {
        alu_op_e           alu_op;
        cmp_op_e           cmp_op;
        mem_op_e           mem_op;
        logic [xlen_p-1:0] alu_in_0;
        logic [xlen_p-1:0] alu_in_1;
        logic [xlen_p-1:0] mem_wr_data;
        ex_out_sel_e       ex_out_sel;
        wb_sel_e           wb_sel;
        logic              gpr_we;
        reg_addr_t         dst_addr;
        logic              illegal;
    } id_ex_t;

endpackage

/* verilog/rv_id_stage.sv */
// ------------------------------------------------
// rv32i instruction decode stage
// decoder, immediate generator and register file
// feeding one id/ex register with valid/ready on
// both the fetch and the execute side
// ------------------------------------------------
`timescale 1ns/1ps

module rv_id_stage import rv_id_pkg::*; #(
    parameter int unsigned DATA_W = xlen_p,
    parameter int unsigned NREGS  = 32
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // fetch side
    input  logic              if_valid_i,
    output logic              if_ready_o,
    input  insn_u             if_insn_i,
    // execute side
    output logic              id_valid_o,
    input  logic              ex_ready_i,
    output id_ex_t            id_ex_o,
    // writeback port
    input  logic              wb_we_i,
    input  reg_addr_t         wb_addr_i,
    input  logic [DATA_W-1:0] wb_data_i
);

    // ------------------------------------------------
    // decode
    // ------------------------------------------------
    alu_op_e           alu_op;
    cmp_op_e           cmp_op;
    mem_op_e           mem_op;
    imm_fmt_e          imm_fmt;
    logic              use_imm;
    ex_out_sel_e       ex_out_sel;
    wb_sel_e           wb_sel;
    logic              gpr_we;
    logic              illegal;
    logic [xlen_p-1:0] imm;
    logic [DATA_W-1:0] rs1_data;
    logic [DATA_W-1:0] rs2_data;
    id_ex_t            id_ex_d;
    logic              accept;

    rv_ctrl_decoder u_ctrl_decoder (
        .insn_i       (if_insn_i),
        .alu_op_o     (alu_op),
        .cmp_op_o     (cmp_op),
        .mem_op_o     (mem_op),
        .imm_fmt_o    (imm_fmt),
        .use_imm_o    (use_imm),
        .ex_out_sel_o (ex_out_sel),
        .wb_sel_o     (wb_sel),
        .gpr_we_o     (gpr_we),
        .illegal_o    (illegal)
    );

    rv_imm_gen u_imm_gen (
        .insn_i (if_insn_i),
        .fmt_i  (imm_fmt),
        .imm_o  (imm)
    );

    // operands read in the accepting cycle
    rv_gpr_file #(
        .DATA_W (DATA_W),
        .NREGS  (NREGS)
    ) u_gpr_file (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_addr_0_i (if_insn_i.r_fmt.rs1),
        .rd_addr_1_i (if_insn_i.r_fmt.rs2),
        .rd_data_0_o (rs1_data),
        .rd_data_1_o (rs2_data),
        .we_i        (wb_we_i),
        .wr_addr_i   (wb_addr_i),
        .wr_data_i   (wb_data_i)
    );

    // result assembly
    always_comb begin
        id_ex_d.alu_op      = alu_op;
        id_ex_d.cmp_op      = cmp_op;
        id_ex_d.mem_op      = mem_op;
        id_ex_d.alu_in_0    = rs1_data;
        id_ex_d.alu_in_1    = use_imm ? imm : rs2_data;
        // store data is always rs2
        id_ex_d.mem_wr_data = rs2_data;
        id_ex_d.ex_out_sel  = ex_out_sel;
        id_ex_d.wb_sel      = wb_sel;
        id_ex_d.gpr_we      = gpr_we;
        id_ex_d.dst_addr    = if_insn_i.r_fmt.rd;
        id_ex_d.illegal     = illegal;
    end

    // ------------------------------------------------
    // id/ex register and handshake
    // ------------------------------------------------
    // free when empty or being drained this cycle
    assign if_ready_o = !id_valid_o || ex_ready_i;
    assign accept     = if_valid_i && if_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_o <= 1'b0;
        end else if (if_ready_o) begin
            id_valid_o <= if_valid_i;
        end
    end

    // payload only moves on accept, holds under stall
    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* verilog/rv_imm_gen.sv */
// ------------------------------------------------
// immediate generator
// builds sign-extended i, shift and s immediates
// and returns the one the decoder asks for
// ------------------------------------------------
`timescale 1ns/1ps

module rv_imm_gen import rv_id_pkg::*; (
    input  insn_u             insn_i,
    input  imm_fmt_e          fmt_i,
    output logic [xlen_p-1:0] imm_o
);

    logic [xlen_p-1:0] imm_i;
    logic [xlen_p-1:0] imm_sh;
    logic [xlen_p-1:0] imm_s;

    // i format, imm[11:0] sits where funct7 and rs2 are
    assign imm_i = {{(xlen_p-12){insn_i.r_fmt.funct7[6]}},
                    insn_i.r_fmt.funct7, insn_i.r_fmt.rs2};

    // shift amount lives in the rs2 slot
    // bit 31 is zero on every legal shift, so this ends up zero-extended
    assign imm_sh = {{(xlen_p-5){insn_i.r_fmt.funct7[6]}}, insn_i.r_fmt.rs2};

    // s format, split field joined back together
    assign imm_s = {{(xlen_p-12){insn_i.s_fmt.imm_hi[6]}},
                    insn_i.s_fmt.imm_hi, insn_i.s_fmt.imm_lo};

    always_comb begin
        case (fmt_i)
            IMM_I:      imm_o = imm_i;
            IMM_ISHIFT: imm_o = imm_sh;
            IMM_S:      imm_o = imm_s;
            // no immediate in use
            default:    imm_o = '0;
        endcase
    end

endmodule
